// ==== rtl/ext_periph_pkg.sv ====
/*
 * shared bus widths, peripheral window indices and register offsets
 * for the external peripheral subsystem
 */
`default_nettype none

package ext_periph_pkg;

  // apb bus widths
  localparam int unsigned APB_ADDR_WIDTH = 12;
  localparam int unsigned APB_DATA_WIDTH = 32;

  typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

  // mapped peripherals with one 256-byte window each
  localparam int unsigned NUM_PERIPH = 3;
  localparam int unsigned IFFIFO_IDX = 0;
  localparam int unsigned POWER_IDX  = 1;
  localparam int unsigned INTR_IDX   = 2;

  typedef logic [NUM_PERIPH-1:0] periph_sel_t;

  // window number sits in paddr[11:8]
  localparam int unsigned PERIPH_SEL_LSB = 8;

  // fifo registers
  localparam logic [PERIPH_SEL_LSB-1:0] REG_FIFO_DATA      = 8'h00;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_FIFO_STATUS    = 8'h04;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_FIFO_WATERMARK = 8'h08;

  // power switch registers
  localparam logic [PERIPH_SEL_LSB-1:0] REG_PWR_REQ    = 8'h00;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_PWR_STATUS = 8'h04;

  // interrupt controller registers
  localparam logic [PERIPH_SEL_LSB-1:0] REG_INTR_PENDING = 8'h00;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_INTR_ENABLE  = 8'h04;

  // fifo status word with the fill count in the low bits
  localparam int unsigned FIFO_EMPTY_BIT = 16;
  localparam int unsigned FIFO_FULL_BIT  = 17;

endpackage

`default_nettype wire

// ==== rtl/apb_periph_decoder.sv ====
/*
 * apb window decoder: one-hot peripheral select, read data mux,
 * zero-wait pready generation and slave error for unmapped windows
 */
`timescale 1ns/1ps
`default_nettype none

module apb_periph_decoder (
  input  wire                                                        clk_i,
  input  wire                                                        rst_n_i,
  input  wire                                                        psel_i,
  input  wire                                                        penable_i,
  input  ext_periph_pkg::apb_addr_t                                  paddr_i,
  input  ext_periph_pkg::apb_data_t [ext_periph_pkg::NUM_PERIPH-1:0] rdata_i,
  output ext_periph_pkg::periph_sel_t                                periph_sel_o,
  output logic                                                       pready_o,
  output ext_periph_pkg::apb_data_t                                  prdata_o,
  output logic                                                       pslverr_o
);

  localparam int unsigned WIN_W =
    ext_periph_pkg::APB_ADDR_WIDTH - ext_periph_pkg::PERIPH_SEL_LSB;

  logic [WIN_W-1:0] win;
  logic             mapped;
  logic             pready_q;

  // upper address bits pick the window
  assign win = paddr_i[ext_periph_pkg::APB_ADDR_WIDTH-1:ext_periph_pkg::PERIPH_SEL_LSB];
  assign mapped = (win < WIN_W'(ext_periph_pkg::NUM_PERIPH));

  // one-hot select and read mux where unmapped windows read zero
  always_comb begin
    periph_sel_o = '0;
    prdata_o     = '0;
    for (int i = 0; i < ext_periph_pkg::NUM_PERIPH; i++) begin
      if (win == WIN_W'(i)) begin
        periph_sel_o[i] = psel_i;
        prdata_o        = rdata_i[i];
      end
    end
  end

  // setup phase seen -> ready in the access cycle that follows
  // never set in an access cycle, so at most one cycle per transfer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pready_q <= 1'b0;
    end else begin
      pready_q <= psel_i & ~penable_i;
    end
  end

  assign pready_o  = pready_q;
  assign pslverr_o = pready_q & ~mapped;

endmodule

`default_nettype wire

// ==== rtl/iffifo.sv ====
/*
 * register-mapped fifo with push/pop data port, status word,
 * watermark level output and dma slot flags
 */
`timescale 1ns/1ps
`default_nettype none

module iffifo #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       psel_i,
  input  wire                       penable_i,
  input  wire                       pwrite_i,
  input  wire [7:0]                 paddr_i,
  input  ext_periph_pkg::apb_data_t pwdata_i,
  output ext_periph_pkg::apb_data_t rdata_o,
  output logic                      in_ready_o,
  output logic                      out_valid_o,
  output logic                      level_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  ext_periph_pkg::apb_data_t mem_q [FIFO_DEPTH];
  ext_periph_pkg::apb_data_t status;

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] watermark_q;
  logic             access;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign access = psel_i & penable_i;
  assign full   = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty  = (count_q == '0);

  // full pushes and empty pops are dropped
  assign push = access & pwrite_i & (paddr_i == ext_periph_pkg::REG_FIFO_DATA) & ~full;
  assign pop  = access & ~pwrite_i & (paddr_i == ext_periph_pkg::REG_FIFO_DATA) & ~empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= pwdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      watermark_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      if (access && pwrite_i && paddr_i == ext_periph_pkg::REG_FIFO_WATERMARK) begin
        watermark_q <= pwdata_i[CNT_W-1:0];
      end
    end
  end

  // count, empty and full packed into one word
  always_comb begin
    status = '0;
    status[CNT_W-1:0] = count_q;
    status[ext_periph_pkg::FIFO_EMPTY_BIT] = empty;
    status[ext_periph_pkg::FIFO_FULL_BIT]  = full;
  end

  always_comb begin
    case (paddr_i)
      ext_periph_pkg::REG_FIFO_DATA:      rdata_o = empty ? '0 : mem_q[rd_ptr_q];
      ext_periph_pkg::REG_FIFO_STATUS:    rdata_o = status;
      ext_periph_pkg::REG_FIFO_WATERMARK: rdata_o = ext_periph_pkg::apb_data_t'(watermark_q);
      default:                            rdata_o = '0;
    endcase
  end

  // dma slots
  assign in_ready_o  = ~full;
  assign out_valid_o = ~empty;

  // a zero watermark disables the level
  assign level_o = (watermark_q != '0) && (count_q >= watermark_q);

endmodule

`default_nettype wire

// ==== rtl/power_switch_ctrl.sv ====
/*
 * power switch sequencer, one fsm per external domain,
 * with request and status registers and a done pulse per transition
 */
`timescale 1ns/1ps
`default_nettype none

module power_switch_ctrl #(
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       psel_i,
  input  wire                       penable_i,
  input  wire                       pwrite_i,
  input  wire [7:0]                 paddr_i,
  input  ext_periph_pkg::apb_data_t pwdata_i,
  input  wire [NUM_DOMAINS-1:0]     switch_ack_n_i,
  output ext_periph_pkg::apb_data_t rdata_o,
  output logic [NUM_DOMAINS-1:0]    switch_n_o,
  output logic [NUM_DOMAINS-1:0]    iso_n_o,
  output logic [NUM_DOMAINS-1:0]    domain_rst_n_o,
  output logic [NUM_DOMAINS-1:0]    done_o
);

  // sequencer states
  localparam logic [2:0] ST_OFF    = 3'd0;
  localparam logic [2:0] ST_UP_ACK = 3'd1;
  localparam logic [2:0] ST_UP_ISO = 3'd2;
  localparam logic [2:0] ST_ON     = 3'd3;
  localparam logic [2:0] ST_DN_ISO = 3'd4;
  localparam logic [2:0] ST_DN_ACK = 3'd5;

  logic [NUM_DOMAINS-1:0] req_q;
  logic [NUM_DOMAINS-1:0] on_status;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q <= '0;
    end else if (psel_i && penable_i && pwrite_i && paddr_i == ext_periph_pkg::REG_PWR_REQ) begin
      req_q <= pwdata_i[NUM_DOMAINS-1:0];
    end
  end

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_domain
    logic [2:0] state_q;
    logic       done_q;

    // requests are only sampled in the settled states
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        state_q <= ST_OFF;
        done_q  <= 1'b0;
      end else begin
        done_q <= 1'b0;
        case (state_q)
          ST_OFF: begin
            if (req_q[d]) state_q <= ST_UP_ACK;
          end
          ST_UP_ACK: begin
            if (!switch_ack_n_i[d]) state_q <= ST_UP_ISO;
          end
          ST_UP_ISO: begin
            state_q <= ST_ON;
            done_q  <= 1'b1;
          end
          ST_ON: begin
            if (!req_q[d]) state_q <= ST_DN_ISO;
          end
          ST_DN_ISO: begin
            state_q <= ST_DN_ACK;
          end
          ST_DN_ACK: begin
            if (switch_ack_n_i[d]) begin
              state_q <= ST_OFF;
              done_q  <= 1'b1;
            end
          end
          default: state_q <= ST_OFF;
        endcase
      end
    end

    // switch closed from power-up until the down sequence opens it
    assign switch_n_o[d]     = (state_q == ST_OFF) || (state_q == ST_DN_ACK);
    assign iso_n_o[d]        = (state_q == ST_UP_ISO) || (state_q == ST_ON);
    assign domain_rst_n_o[d] = (state_q == ST_ON);
    // status stays on until the power-down sequence completes
    assign on_status[d]      = (state_q == ST_ON) || (state_q == ST_DN_ISO) ||
                               (state_q == ST_DN_ACK);
    assign done_o[d]         = done_q;
  end

  always_comb begin
    case (paddr_i)
      ext_periph_pkg::REG_PWR_REQ:    rdata_o = ext_periph_pkg::apb_data_t'(req_q);
      ext_periph_pkg::REG_PWR_STATUS: rdata_o = ext_periph_pkg::apb_data_t'(on_status);
      default:                        rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/intr_ctrl.sv ====
/*
 * interrupt controller: pending and enable registers,
 * write-one-to-clear pending, one combined interrupt line
 */
`timescale 1ns/1ps
`default_nettype none

module intr_ctrl #(
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       psel_i,
  input  wire                       penable_i,
  input  wire                       pwrite_i,
  input  wire [7:0]                 paddr_i,
  input  ext_periph_pkg::apb_data_t pwdata_i,
  input  wire                       fifo_level_i,
  input  wire [NUM_DOMAINS-1:0]     power_done_i,
  output ext_periph_pkg::apb_data_t rdata_o,
  output logic                      intr_o
);

  // bit 0 fifo level, bit 1+d done of domain d
  localparam int unsigned NUM_SRC = NUM_DOMAINS + 1;

  logic [NUM_SRC-1:0] src;
  logic [NUM_SRC-1:0] clr;
  logic [NUM_SRC-1:0] pending_q;
  logic [NUM_SRC-1:0] enable_q;
  logic               wr_en;

  assign src   = {power_done_i, fifo_level_i};
  assign wr_en = psel_i & penable_i & pwrite_i;
  assign clr   = (wr_en && paddr_i == ext_periph_pkg::REG_INTR_PENDING) ?
                 pwdata_i[NUM_SRC-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // a live source wins over a clear
      pending_q <= (pending_q & ~clr) | src;
      if (wr_en && paddr_i == ext_periph_pkg::REG_INTR_ENABLE) begin
        enable_q <= pwdata_i[NUM_SRC-1:0];
      end
    end
  end

  always_comb begin
    case (paddr_i)
      ext_periph_pkg::REG_INTR_PENDING: rdata_o = ext_periph_pkg::apb_data_t'(pending_q);
      ext_periph_pkg::REG_INTR_ENABLE:  rdata_o = ext_periph_pkg::apb_data_t'(enable_q);
      default:                          rdata_o = '0;
    endcase
  end

  assign intr_o = |(pending_q & enable_q);

endmodule

`default_nettype wire

// ==== rtl/ext_periph_subsys.sv ====
/*
 * external peripheral subsystem top: apb decoder, fifo,
 * power switch sequencer and interrupt controller
 */
`timescale 1ns/1ps
`default_nettype none

module ext_periph_subsys #(
  parameter int unsigned FIFO_DEPTH  = 8,
  parameter int unsigned NUM_DOMAINS = 2
) (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       psel_i,
  input  wire                       penable_i,
  input  wire                       pwrite_i,
  input  ext_periph_pkg::apb_addr_t paddr_i,
  input  ext_periph_pkg::apb_data_t pwdata_i,
  output logic                      pready_o,
  output ext_periph_pkg::apb_data_t prdata_o,
  output logic                      pslverr_o,
  output logic                      fifo_in_ready_o,
  output logic                      fifo_out_valid_o,
  output logic [NUM_DOMAINS-1:0]    switch_n_o,
  input  wire  [NUM_DOMAINS-1:0]    switch_ack_n_i,
  output logic [NUM_DOMAINS-1:0]    iso_n_o,
  output logic [NUM_DOMAINS-1:0]    domain_rst_n_o,
  output logic                      intr_o
);

  ext_periph_pkg::periph_sel_t                                periph_sel;
  ext_periph_pkg::apb_data_t [ext_periph_pkg::NUM_PERIPH-1:0] periph_rdata;

  logic [ext_periph_pkg::PERIPH_SEL_LSB-1:0] periph_addr;
  logic                                      fifo_level;
  logic [NUM_DOMAINS-1:0]                    power_done;

  // offset within the selected window
  assign periph_addr = paddr_i[ext_periph_pkg::PERIPH_SEL_LSB-1:0];

  apb_periph_decoder apb_periph_decoder_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .paddr_i      (paddr_i),
    .rdata_i      (periph_rdata),
    .periph_sel_o (periph_sel),
    .pready_o     (pready_o),
    .prdata_o     (prdata_o),
    .pslverr_o    (pslverr_o)
  );

  iffifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) iffifo_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .psel_i      (periph_sel[ext_periph_pkg::IFFIFO_IDX]),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (periph_addr),
    .pwdata_i    (pwdata_i),
    .rdata_o     (periph_rdata[ext_periph_pkg::IFFIFO_IDX]),
    .in_ready_o  (fifo_in_ready_o),
    .out_valid_o (fifo_out_valid_o),
    .level_o     (fifo_level)
  );

  power_switch_ctrl #(
    .NUM_DOMAINS (NUM_DOMAINS)
  ) power_switch_ctrl_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .psel_i         (periph_sel[ext_periph_pkg::POWER_IDX]),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (periph_addr),
    .pwdata_i       (pwdata_i),
    .switch_ack_n_i (switch_ack_n_i),
    .rdata_o        (periph_rdata[ext_periph_pkg::POWER_IDX]),
    .switch_n_o     (switch_n_o),
    .iso_n_o        (iso_n_o),
    .domain_rst_n_o (domain_rst_n_o),
    .done_o         (power_done)
  );

  intr_ctrl #(
    .NUM_DOMAINS (NUM_DOMAINS)
  ) intr_ctrl_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .psel_i       (periph_sel[ext_periph_pkg::INTR_IDX]),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (periph_addr),
    .pwdata_i     (pwdata_i),
    .fifo_level_i (fifo_level),
    .power_done_i (power_done),
    .rdata_o      (periph_rdata[ext_periph_pkg::INTR_IDX]),
    .intr_o       (intr_o)
  );

endmodule

`default_nettype wire

// ==== tb/ext_periph_checker.sv ====
/*
 * concurrent assertions on power sequencing and the apb response
 */
`timescale 1ns/1ps
`default_nettype none

module ext_periph_checker #(
  parameter int unsigned NUM_DOMAINS = 2
) (
  input wire                   clk_i,
  input wire                   rst_n_i,
  input wire                   pready_i,
  input wire                   pslverr_i,
  input wire [NUM_DOMAINS-1:0] switch_n_i,
  input wire [NUM_DOMAINS-1:0] iso_n_i,
  input wire [NUM_DOMAINS-1:0] domain_rst_n_i
);

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_domain
    // isolation only released while the switch is closed
    iso_needs_switch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iso_n_i[d] |-> !switch_n_i[d])
      else $error("domain %0d isolation released with the switch open", d);

    rst_needs_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      domain_rst_n_i[d] |-> iso_n_i[d])
      else $error("domain %0d reset released while isolated", d);
  end

  slverr_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pslverr_i |-> pready_i)
    else $error("pslverr raised without pready");

  // zero-wait slaves give one ready cycle per transfer
  ready_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pready_i |=> !pready_i)
    else $error("pready high for two cycles in a row");

endmodule

`default_nettype wire

// ==== tb/tb_ext_periph_subsys.sv ====
/*
 * testbench for the external peripheral subsystem: apb driver,
 * switch-ack model, lfsr data and directed tests
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ext_periph_subsys;

  localparam int unsigned FIFO_DEPTH         = 8;
  localparam int unsigned NUM_DOMAINS        = 2;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  // about 55 transfers of 3 cycles plus two power sequences fit well inside
  localparam int unsigned TIMEOUT_CYCLES     = 3000;
  localparam int unsigned POLL_LIMIT         = 40;

  // register addresses with the window number above the byte offset
  localparam ext_periph_pkg::apb_addr_t ADDR_FIFO_DATA =
    {4'(ext_periph_pkg::IFFIFO_IDX), ext_periph_pkg::REG_FIFO_DATA};
  localparam ext_periph_pkg::apb_addr_t ADDR_FIFO_STATUS =
    {4'(ext_periph_pkg::IFFIFO_IDX), ext_periph_pkg::REG_FIFO_STATUS};
  localparam ext_periph_pkg::apb_addr_t ADDR_FIFO_WM =
    {4'(ext_periph_pkg::IFFIFO_IDX), ext_periph_pkg::REG_FIFO_WATERMARK};
  localparam ext_periph_pkg::apb_addr_t ADDR_PWR_REQ =
    {4'(ext_periph_pkg::POWER_IDX), ext_periph_pkg::REG_PWR_REQ};
  localparam ext_periph_pkg::apb_addr_t ADDR_PWR_STATUS =
    {4'(ext_periph_pkg::POWER_IDX), ext_periph_pkg::REG_PWR_STATUS};
  localparam ext_periph_pkg::apb_addr_t ADDR_INTR_PENDING =
    {4'(ext_periph_pkg::INTR_IDX), ext_periph_pkg::REG_INTR_PENDING};
  localparam ext_periph_pkg::apb_addr_t ADDR_INTR_ENABLE =
    {4'(ext_periph_pkg::INTR_IDX), ext_periph_pkg::REG_INTR_ENABLE};
  localparam ext_periph_pkg::apb_addr_t ADDR_UNMAPPED   = 12'h300;
  localparam ext_periph_pkg::apb_addr_t ADDR_PWR_UNUSED = 12'h110;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  ext_periph_pkg::apb_addr_t paddr;
  ext_periph_pkg::apb_data_t pwdata;
  logic                      pready;
  ext_periph_pkg::apb_data_t prdata;
  logic                      pslverr;
  logic                      fifo_in_ready;
  logic                      fifo_out_valid;
  logic [NUM_DOMAINS-1:0]    switch_n;
  logic [NUM_DOMAINS-1:0]    switch_ack_n;
  logic [NUM_DOMAINS-1:0]    iso_n;
  logic [NUM_DOMAINS-1:0]    domain_rst_n;
  logic                      intr;

  logic [SWITCH_ACK_LATENCY-1:0][NUM_DOMAINS-1:0] ack_pipe    = '1;
  logic [15:0]                                    lfsr_q      = 16'd87;
  int unsigned                                    cycle_count = 0;

  ext_periph_subsys #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .NUM_DOMAINS (NUM_DOMAINS)
  ) ext_periph_subsys_inst (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .psel_i           (psel),
    .penable_i        (penable),
    .pwrite_i         (pwrite),
    .paddr_i          (paddr),
    .pwdata_i         (pwdata),
    .pready_o         (pready),
    .prdata_o         (prdata),
    .pslverr_o        (pslverr),
    .fifo_in_ready_o  (fifo_in_ready),
    .fifo_out_valid_o (fifo_out_valid),
    .switch_n_o       (switch_n),
    .switch_ack_n_i   (switch_ack_n),
    .iso_n_o          (iso_n),
    .domain_rst_n_o   (domain_rst_n),
    .intr_o           (intr)
  );

  bind ext_periph_subsys ext_periph_checker #(
    .NUM_DOMAINS (NUM_DOMAINS)
  ) ext_periph_checker_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .pready_i       (pready_o),
    .pslverr_i      (pslverr_o),
    .switch_n_i     (switch_n_o),
    .iso_n_i        (iso_n_o),
    .domain_rst_n_i (domain_rst_n_o)
  );

  always #5 clk = ~clk;

  // external switch acks after a fixed delay
  always @(posedge clk) begin
    ack_pipe <= {ack_pipe[SWITCH_ACK_LATENCY-2:0], switch_n};
  end
  assign switch_ack_n = ack_pipe[SWITCH_ACK_LATENCY-1];

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  task automatic stop_on_error();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input ext_periph_pkg::apb_data_t got,
                            input ext_periph_pkg::apb_data_t exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_domain(input int d, input logic sw, input logic iso, input logic rst);
    check_bit($sformatf("switch_n_o[%0d]", d), switch_n[d], sw);
    check_bit($sformatf("iso_n_o[%0d]", d), iso_n[d], iso);
    check_bit($sformatf("domain_rst_n_o[%0d]", d), domain_rst_n[d], rst);
  endtask

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_random_word(output ext_periph_pkg::apb_data_t word);
    word = '0;
    for (int i = 0; i < ext_periph_pkg::APB_DATA_WIDTH; i++) begin
      word   = {word[ext_periph_pkg::APB_DATA_WIDTH-2:0], lfsr_q[15]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // count in the low bits, empty and full flags above
  function automatic ext_periph_pkg::apb_data_t fifo_status(input int unsigned count);
    ext_periph_pkg::apb_data_t word;
    word = ext_periph_pkg::apb_data_t'(count);
    word[ext_periph_pkg::FIFO_EMPTY_BIT] = (count == 0);
    word[ext_periph_pkg::FIFO_FULL_BIT]  = (count == FIFO_DEPTH);
    return word;
  endfunction

  task automatic apb_transfer(input logic write, input ext_periph_pkg::apb_addr_t addr,
                              input ext_periph_pkg::apb_data_t wdata,
                              output ext_periph_pkg::apb_data_t rdata, output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input ext_periph_pkg::apb_addr_t addr,
                           input ext_periph_pkg::apb_data_t data);
    ext_periph_pkg::apb_data_t rdata;
    logic                      slverr;
    apb_transfer(1'b1, addr, data, rdata, slverr);
    check_bit("pslverr_o", slverr, 1'b0);
  endtask

  task automatic apb_read(input ext_periph_pkg::apb_addr_t addr,
                          output ext_periph_pkg::apb_data_t data, output logic slverr);
    apb_transfer(1'b0, addr, '0, data, slverr);
  endtask

  task automatic wait_power_status(input int d, input logic want);
    ext_periph_pkg::apb_data_t rdata;
    logic                      slverr;
    int unsigned               polls;
    for (polls = 0; polls < POLL_LIMIT; polls++) begin
      @(negedge clk);
      // nothing released before the switch acks
      if (switch_ack_n[d]) begin
        check_bit($sformatf("iso_n_o[%0d]", d), iso_n[d], 1'b0);
        check_bit($sformatf("domain_rst_n_o[%0d]", d), domain_rst_n[d], 1'b0);
      end
      apb_read(ADDR_PWR_STATUS, rdata, slverr);
      if (rdata[d] == want) break;
    end
    if (polls == POLL_LIMIT) begin
      $display("domain %0d never reached power state %0d", d, want);
      stop_on_error();
    end
  endtask

  task automatic test_reset_values();
    @(negedge clk);
    check_bit("pready_o", pready, 1'b0);
    check_bit("pslverr_o", pslverr, 1'b0);
    check_bit("fifo_in_ready_o", fifo_in_ready, 1'b1);
    check_bit("fifo_out_valid_o", fifo_out_valid, 1'b0);
    check_bit("intr_o", intr, 1'b0);
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      check_domain(d, 1'b1, 1'b0, 1'b0);
    end
  endtask

  task automatic test_fifo_order();
    ext_periph_pkg::apb_data_t expected [$];
    ext_periph_pkg::apb_data_t word;
    ext_periph_pkg::apb_data_t rdata;
    logic                      slverr;
    for (int unsigned i = 0; i < FIFO_DEPTH; i++) begin
      next_random_word(word);
      apb_write(ADDR_FIFO_DATA, word);
      expected.push_back(word);
    end
    @(negedge clk);
    check_bit("fifo_in_ready_o", fifo_in_ready, 1'b0);
    check_bit("fifo_out_valid_o", fifo_out_valid, 1'b1);
    apb_read(ADDR_FIFO_STATUS, rdata, slverr);
    check_word("prdata_o", rdata, fifo_status(FIFO_DEPTH));
    // this push is dropped as the fifo is full
    next_random_word(word);
    apb_write(ADDR_FIFO_DATA, word);
    apb_read(ADDR_FIFO_STATUS, rdata, slverr);
    check_word("prdata_o", rdata, fifo_status(FIFO_DEPTH));
    while (expected.size() > 0) begin
      apb_read(ADDR_FIFO_DATA, rdata, slverr);
      check_word("prdata_o", rdata, expected.pop_front());
    end
    apb_read(ADDR_FIFO_STATUS, rdata, slverr);
    check_word("prdata_o", rdata, fifo_status(0));
    @(negedge clk);
    check_bit("fifo_out_valid_o", fifo_out_valid, 1'b0);
    apb_read(ADDR_FIFO_DATA, rdata, slverr);
    check_word("prdata_o", rdata, '0);
  endtask

  task automatic test_watermark_intr();
    ext_periph_pkg::apb_data_t first;
    ext_periph_pkg::apb_data_t word;
    ext_periph_pkg::apb_data_t rdata;
    logic                      slverr;
    first = '0;
    apb_write(ADDR_FIFO_WM, 32'd3);
    apb_write(ADDR_INTR_ENABLE, 32'h1);
    for (int i = 0; i < 3; i++) begin
      next_random_word(word);
      apb_write(ADDR_FIFO_DATA, word);
      if (i == 0) first = word;
    end
    // level rises after the push and pending one cycle later
    repeat (2) @(negedge clk);
    check_bit("intr_o", intr, 1'b1);
    apb_read(ADDR_FIFO_DATA, rdata, slverr);
    check_word("prdata_o", rdata, first);
    apb_write(ADDR_INTR_PENDING, 32'h1);
    apb_read(ADDR_INTR_PENDING, rdata, slverr);
    check_word("prdata_o", rdata, '0);
    @(negedge clk);
    check_bit("intr_o", intr, 1'b0);
  endtask

  task automatic test_power_up();
    ext_periph_pkg::apb_data_t rdata;
    logic                      slverr;
    apb_write(ADDR_PWR_REQ, 32'h1);
    wait_power_status(0, 1'b1);
    @(negedge clk);
    check_domain(0, 1'b0, 1'b1, 1'b1);
    check_domain(1, 1'b1, 1'b0, 1'b0);
    apb_read(ADDR_INTR_PENDING, rdata, slverr);
    check_word("prdata_o", rdata, 32'h2);
    apb_write(ADDR_INTR_PENDING, 32'h2);
  endtask

  task automatic test_power_down();
    ext_periph_pkg::apb_data_t rdata;
    logic                      slverr;
    apb_write(ADDR_INTR_ENABLE, 32'h2);
    apb_write(ADDR_PWR_REQ, 32'h0);
    repeat (2) @(negedge clk);
    // isolation and reset drop first while the switch stays closed
    check_domain(0, 1'b0, 1'b0, 1'b0);
    wait_power_status(0, 1'b0);
    @(negedge clk);
    check_domain(0, 1'b1, 1'b0, 1'b0);
    check_bit("intr_o", intr, 1'b1);
    apb_write(ADDR_INTR_PENDING, 32'h2);
    @(negedge clk);
    check_bit("intr_o", intr, 1'b0);
    apb_read(ADDR_INTR_PENDING, rdata, slverr);
    check_word("prdata_o", rdata, '0);
  endtask

  task automatic test_address_decode();
    ext_periph_pkg::apb_data_t rdata;
    logic                      slverr;
    apb_read(ADDR_UNMAPPED, rdata, slverr);
    check_bit("pslverr_o", slverr, 1'b1);
    check_word("prdata_o", rdata, '0);
    apb_read(ADDR_PWR_UNUSED, rdata, slverr);
    check_bit("pslverr_o", slverr, 1'b0);
    check_word("prdata_o", rdata, '0);
    apb_write(ADDR_FIFO_WM, 32'd5);
    apb_read(ADDR_FIFO_WM, rdata, slverr);
    check_bit("pslverr_o", slverr, 1'b0);
    check_word("prdata_o", rdata, 32'd5);
  endtask

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_values();
    test_fifo_order();
    test_watermark_intr();
    test_power_up();
    test_power_down();
    test_address_decode();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/ext_periph_pkg.sv
rtl/apb_periph_decoder.sv
rtl/iffifo.sv
rtl/power_switch_ctrl.sv
rtl/intr_ctrl.sv
rtl/ext_periph_subsys.sv
tb/ext_periph_checker.sv
tb/tb_ext_periph_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator, pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ext_periph_subsys -f all.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
exit 1
